//--- build.f
hdl/pq_data_pkg.sv
hdl/pq_ctrl_pkg.sv
hdl/pq_key_ram.sv
hdl/pq_datapath.sv
hdl/pq_status_regs.sv
hdl/pq_control_fsm.sv
hdl/pq_top.sv
dv/pq_assertions.sv
dv/pq_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the priority queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module pq_tb -Mdir obj_dir -f build.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

# Assertion errors must not end the run before the testbench sees them
./obj_dir/Vpq_tb +verilator+error+limit+1000
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0

//--- dv/pq_tb.sv
`timescale 1ns/1ps

module pq_tb;

  localparam int IDLE_TIMEOUT = 100;
  localparam int QUIET_CYCLES = 12;
  localparam int DEQ_LATENCY  = 2;

  logic                 clk;
  logic                 rst;
  logic                 enq;
  pq_data_pkg::key_t    enq_key;
  logic                 deq;
  logic                 busy;
  logic                 deq_valid;
  pq_data_pkg::key_t    deq_key;
  logic                 full;
  logic                 empty;
  pq_data_pkg::count_t  count;

  // Queued keys of the reference model in no particular order
  pq_data_pkg::key_t    model[$];
  string                test_name;

  pq_top pq_top_i (
    .clk       (clk),
    .rst       (rst),
    .enq       (enq),
    .enq_key   (enq_key),
    .deq       (deq),
    .busy      (busy),
    .deq_valid (deq_valid),
    .deq_key   (deq_key),
    .full      (full),
    .empty     (empty),
    .count     (count)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    assert (actual == expected)
    else
    begin
      abort_run($sformatf("Error %s %s: expected %0d, actual %0d",
                          test_name, what, expected, actual));
    end
  endtask

  task automatic check_status();
    check_value("count", model.size(), int'(count));
    check_value("full", int'(model.size() == pq_data_pkg::DEPTH), int'(full));
    check_value("empty", int'(model.size() == 0), int'(empty));
    check_value("busy", 0, int'(busy));
  endtask

  always @(negedge clk)
  begin
    if (pq_top_i.pq_assertions_i.fail_count != 0)
    begin
      abort_run("A bound assertion on the DUT failed");
    end
  end

  ////////////////////////////////////////
  // Model and stimulus
  ////////////////////////////////////////

  function automatic pq_data_pkg::key_t pop_model_min();
    int                 min_idx;
    pq_data_pkg::key_t  min_key;
    min_idx = 0;
    for (int i = 1; i < model.size(); i++)
    begin
      if (model[i] < model[min_idx])
      begin
        min_idx = i;
      end
    end
    min_key = model[min_idx];
    model.delete(min_idx);
    return min_key;
  endfunction

  function automatic pq_data_pkg::key_t random_key();
    return pq_data_pkg::key_t'($urandom);
  endfunction

  // Held for three rising edges and released on a falling edge
  task automatic apply_reset();
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    model.delete();
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy)
    begin
      if (cycles == IDLE_TIMEOUT)
      begin
        abort_run($sformatf("Timeout in %s, busy stayed high", test_name));
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // Drives both strobes for one cycle while the DUT is busy
  task automatic poke_strobes();
    check_value("busy before poke", 1, int'(busy));
    enq     = 1'b1;
    deq     = 1'b1;
    enq_key = random_key();
    @(negedge clk);
    enq = 1'b0;
    deq = 1'b0;
  endtask

  // Starts and ends on a falling edge with the DUT idle
  task automatic run_command(input logic do_enq, input logic do_deq,
                             input pq_data_pkg::key_t key, input logic poke);
    pq_data_pkg::key_t  expected;
    int                 cycles;
    wait_idle();
    enq     = do_enq;
    deq     = do_deq;
    enq_key = key;
    @(negedge clk);
    enq    = 1'b0;
    deq    = 1'b0;
    cycles = 1;
    if (do_enq)
    begin
      if (model.size() < pq_data_pkg::DEPTH)
      begin
        model.push_back(key);
        check_value("busy after enq", 1, int'(busy));
        if (poke)
        begin
          poke_strobes();
        end
        wait_idle();
      end
      else
      begin
        check_value("busy after enq while full", 0, int'(busy));
      end
    end
    else if (model.size() > 0)
    begin
      expected = pop_model_min();
      if (poke)
      begin
        poke_strobes();
        cycles = 2;
      end
      while (!deq_valid)
      begin
        if (cycles == IDLE_TIMEOUT)
        begin
          abort_run($sformatf("Timeout in %s, deq_valid never came", test_name));
        end
        @(negedge clk);
        cycles++;
      end
      check_value("deq latency", DEQ_LATENCY, cycles);
      check_value("deq_key", int'(expected), int'(deq_key));
      check_value("count at deq_valid", model.size(), int'(count));
      wait_idle();
    end
    else
    begin
      repeat (QUIET_CYCLES)
      begin
        if (deq_valid || busy)
        begin
          abort_run($sformatf("In %s a dequeue while empty produced output", test_name));
        end
        @(negedge clk);
      end
    end
    check_status();
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    int                 r;
    logic               p;
    pq_data_pkg::key_t  k;
    void'($urandom(91));
    rst       = 1'b1;
    enq       = 1'b0;
    deq       = 1'b0;
    enq_key   = '0;
    test_name = "reset";
    apply_reset();
    check_status();
    check_value("deq_valid", 0, int'(deq_valid));

    test_name = "ordering";
    repeat (10) run_command(1'b1, 1'b0, random_key(), 1'b0);
    repeat (10) run_command(1'b0, 1'b1, '0, 1'b0);

    // Reset lands in the middle of an enqueue walk
    test_name = "reset while busy";
    repeat (5) run_command(1'b1, 1'b0, random_key(), 1'b0);
    enq     = 1'b1;
    enq_key = random_key();
    @(negedge clk);
    enq = 1'b0;
    check_value("busy before reset", 1, int'(busy));
    apply_reset();
    check_status();
    check_value("deq_valid", 0, int'(deq_valid));

    // Last enqueue lands on a full queue
    test_name = "full";
    repeat (17) run_command(1'b1, 1'b0, random_key(), 1'b0);
    repeat (16) run_command(1'b0, 1'b1, '0, 1'b0);

    test_name = "empty";
    run_command(1'b0, 1'b1, '0, 1'b0);

    test_name = "busy";
    repeat (4) run_command(1'b1, 1'b0, random_key(), 1'b1);
    repeat (3) run_command(1'b0, 1'b1, '0, 1'b1);

    // Small key range forces duplicates
    test_name = "mixed";
    for (int n = 0; n < 200; n++)
    begin
      r = int'($urandom_range(9));
      k = pq_data_pkg::key_t'($urandom_range(7));
      p = ($urandom_range(7) == 0);
      if (r < 4)
      begin
        run_command(1'b1, 1'b0, k, p);
      end
      else if (r < 9)
      begin
        run_command(1'b0, 1'b1, k, p);
      end
      else
      begin
        run_command(1'b1, 1'b1, k, p);
      end
    end

    if (pq_top_i.pq_assertions_i.fail_count != 0)
    begin
      abort_run("A bound assertion on the DUT failed");
    end
    else
    begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

//--- dv/pq_assertions.sv
`timescale 1ns/1ps

module pq_assertions (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 busy,
  input  logic                 deq_valid,
  input  logic                 full,
  input  logic                 empty,
  input  pq_data_pkg::count_t  count
);

  // Failed property count, read by the testbench
  int fail_count = 0;

  ////////////////////////////////////////
  // Status flags
  ////////////////////////////////////////

  flags_match_count: assert property (
    @(posedge clk) disable iff (rst)
    (full == (count == pq_data_pkg::count_t'(pq_data_pkg::DEPTH))) &&
    (empty == (count == '0))
  )
  else
  begin
    fail_count++;
    $error("full or empty disagrees with count %0d", count);
  end

  // At most one insert or one removal per edge
  count_single_step: assert property (
    @(posedge clk) disable iff (rst)
    (count == $past(count)) ||
    (count == $past(count) + pq_data_pkg::count_t'(1)) ||
    (count == $past(count) - pq_data_pkg::count_t'(1))
  )
  else
  begin
    fail_count++;
    $error("count jumped from %0d to %0d", $past(count), count);
  end

  ////////////////////////////////////////
  // Output and control
  ////////////////////////////////////////

  // The command edge is two edges before the deq_valid sample
  no_deq_from_empty: assert property (
    @(posedge clk) disable iff (rst)
    deq_valid |-> !$past(empty, 2)
  )
  else
  begin
    fail_count++;
    $error("deq_valid fired for a command issued while empty");
  end

  idle_in_reset: assert property (
    @(posedge clk)
    $past(rst) |-> (!busy && !deq_valid)
  )
  else
  begin
    fail_count++;
    $error("busy or deq_valid high after a reset edge");
  end

endmodule

bind pq_top pq_assertions pq_assertions_i (
  .clk       (clk),
  .rst       (rst),
  .busy      (busy),
  .deq_valid (deq_valid),
  .full      (full),
  .empty     (empty),
  .count     (count)
);

//--- hdl/pq_top.sv
`timescale 1ns/1ps

module pq_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 enq,
  input  pq_data_pkg::key_t    enq_key,
  input  logic                 deq,
  output logic                 busy,
  output logic                 deq_valid,
  output pq_data_pkg::key_t    deq_key,
  output logic                 full,
  output logic                 empty,
  output pq_data_pkg::count_t  count
);

  // Key RAM port
  pq_data_pkg::addr_t    rd_addr;
  pq_data_pkg::addr_t    wr_addr;
  pq_data_pkg::key_t     wr_data;
  pq_data_pkg::key_t     rd_data;
  logic                  we;

  // Datapath control and results
  logic                  load;
  pq_ctrl_pkg::in_sel_t  in_sel;
  pq_data_pkg::key_t     carry_key;
  logic                  carry_less;

  // Occupancy updates
  logic                  inc;
  logic                  dec;

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  pq_control_fsm pq_control_fsm_i (
    .clk        (clk),
    .rst        (rst),
    .enq        (enq),
    .deq        (deq),
    .full       (full),
    .empty      (empty),
    .count      (count),
    .carry_less (carry_less),
    .rd_data    (rd_data),
    .carry_key  (carry_key),
    .busy       (busy),
    .deq_valid  (deq_valid),
    .deq_key    (deq_key),
    .rd_addr    (rd_addr),
    .we         (we),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .load       (load),
    .in_sel     (in_sel),
    .inc        (inc),
    .dec        (dec)
  );

  pq_status_regs pq_status_regs_i (
    .clk   (clk),
    .rst   (rst),
    .inc   (inc),
    .dec   (dec),
    .count (count),
    .full  (full),
    .empty (empty)
  );

  pq_datapath pq_datapath_i (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .in_sel     (in_sel),
    .enq_key    (enq_key),
    .rd_data    (rd_data),
    .carry_key  (carry_key),
    .carry_less (carry_less)
  );

  pq_key_ram pq_key_ram_i (
    .clk     (clk),
    .we      (we),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

//--- hdl/pq_control_fsm.sv
`timescale 1ns/1ps

module pq_control_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   enq,
  input  logic                   deq,
  input  logic                   full,
  input  logic                   empty,
  input  pq_data_pkg::count_t    count,
  input  logic                   carry_less,
  input  pq_data_pkg::key_t      rd_data,
  input  pq_data_pkg::key_t      carry_key,
  output logic                   busy,
  output logic                   deq_valid,
  output pq_data_pkg::key_t      deq_key,
  output pq_data_pkg::addr_t     rd_addr,
  output logic                   we,
  output pq_data_pkg::addr_t     wr_addr,
  output pq_data_pkg::key_t      wr_data,
  output logic                   load,
  output pq_ctrl_pkg::in_sel_t   in_sel,
  output logic                   inc,
  output logic                   dec
);

  pq_ctrl_pkg::pq_state_t state;
  pq_ctrl_pkg::pq_state_t next_state;

  // Slot index for the enqueue walk and the dequeue shift
  pq_data_pkg::addr_t     idx;
  pq_data_pkg::addr_t     idx_next;
  pq_data_pkg::count_t    idx_inc;

  assign idx_inc = {1'b0, idx} + pq_data_pkg::count_t'(1);

  ////////////////////////////////////////
  // State and index registers
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= pq_ctrl_pkg::IDLE;
      idx   <= '0;
    end
    else
    begin
      state <= next_state;
      idx   <= idx_next;
    end
  end

  ////////////////////////////////////////
  // Next state and control strobes
  ////////////////////////////////////////

  always_comb
  begin
    next_state = state;
    idx_next   = idx;
    rd_addr    = idx;
    we         = 1'b0;
    wr_addr    = idx;
    wr_data    = carry_key;
    load       = 1'b0;
    in_sel     = pq_ctrl_pkg::SEL_INPUT;
    inc        = 1'b0;
    dec        = 1'b0;

    case (state)
      pq_ctrl_pkg::IDLE:
      begin
        // enq has priority, full or empty turns a command into a no-op
        if (enq)
        begin
          if (!full)
          begin
            load       = 1'b1;
            next_state = pq_ctrl_pkg::ENQ_LOAD;
          end
        end
        else if (deq && !empty)
        begin
          next_state = pq_ctrl_pkg::DEQ_READ;
        end
      end

      pq_ctrl_pkg::ENQ_LOAD:
      begin
        idx_next = '0;
        if (count == '0)
        begin
          next_state = pq_ctrl_pkg::ENQ_PLACE;
        end
        else
        begin
          next_state = pq_ctrl_pkg::ENQ_READ;
        end
      end

      pq_ctrl_pkg::ENQ_READ:
      begin
        next_state = pq_ctrl_pkg::ENQ_COMPARE;
      end

      // Slot key arrives here, rd_addr held so it stays for the swap
      pq_ctrl_pkg::ENQ_COMPARE:
      begin
        next_state = pq_ctrl_pkg::ENQ_SWAP;
      end

      pq_ctrl_pkg::ENQ_SWAP:
      begin
        // Carry goes into the slot, the old slot key becomes the carry
        if (carry_less)
        begin
          we     = 1'b1;
          load   = 1'b1;
          in_sel = pq_ctrl_pkg::SEL_RAM;
        end
        idx_next = idx_inc[pq_data_pkg::ADDR_W-1:0];
        if (idx_inc == count)
        begin
          next_state = pq_ctrl_pkg::ENQ_PLACE;
        end
        else
        begin
          next_state = pq_ctrl_pkg::ENQ_READ;
        end
      end

      // idx equals count here, the first free slot
      pq_ctrl_pkg::ENQ_PLACE:
      begin
        we         = 1'b1;
        inc        = 1'b1;
        next_state = pq_ctrl_pkg::IDLE;
      end

      pq_ctrl_pkg::DEQ_READ:
      begin
        rd_addr    = '0;
        dec        = 1'b1;
        next_state = pq_ctrl_pkg::DEQ_PRESENT;
      end

      // count already holds the remaining entries
      pq_ctrl_pkg::DEQ_PRESENT:
      begin
        idx_next = '0;
        if (count == '0)
        begin
          next_state = pq_ctrl_pkg::DEQ_CLEAR;
        end
        else
        begin
          next_state = pq_ctrl_pkg::DEQ_SHIFT_READ;
        end
      end

      pq_ctrl_pkg::DEQ_SHIFT_READ:
      begin
        rd_addr    = idx_inc[pq_data_pkg::ADDR_W-1:0];
        next_state = pq_ctrl_pkg::DEQ_SHIFT_WRITE;
      end

      // Entry idx+1 moves down into idx
      pq_ctrl_pkg::DEQ_SHIFT_WRITE:
      begin
        we       = 1'b1;
        wr_data  = rd_data;
        idx_next = idx_inc[pq_data_pkg::ADDR_W-1:0];
        if (idx_inc == count)
        begin
          next_state = pq_ctrl_pkg::DEQ_CLEAR;
        end
        else
        begin
          next_state = pq_ctrl_pkg::DEQ_SHIFT_READ;
        end
      end

      pq_ctrl_pkg::DEQ_CLEAR:
      begin
        we         = 1'b1;
        wr_data    = pq_data_pkg::SENTINEL;
        next_state = pq_ctrl_pkg::IDLE;
      end

      default:
      begin
        next_state = pq_ctrl_pkg::IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign busy      = (state != pq_ctrl_pkg::IDLE);
  assign deq_valid = (state == pq_ctrl_pkg::DEQ_PRESENT);
  // Slot 0 read data, valid while deq_valid is high
  assign deq_key   = rd_data;

endmodule

//--- hdl/pq_status_regs.sv
`timescale 1ns/1ps

module pq_status_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inc,
  input  logic                 dec,
  output pq_data_pkg::count_t  count,
  output logic                 full,
  output logic                 empty
);

  pq_data_pkg::count_t count_next;

  ////////////////////////////////////////
  // Next occupancy
  ////////////////////////////////////////

  // Saturate at both ends
  always_comb
  begin
    count_next = count;
    if (inc && !dec && !full)
    begin
      count_next = count + pq_data_pkg::count_t'(1);
    end
    else if (dec && !inc && !empty)
    begin
      count_next = count - pq_data_pkg::count_t'(1);
    end
  end

  ////////////////////////////////////////
  // Count and flags
  ////////////////////////////////////////

  // Flags come from count_next so all three update on one edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end
    else
    begin
      count <= count_next;
      full  <= (count_next == pq_data_pkg::count_t'(pq_data_pkg::DEPTH));
      empty <= (count_next == '0);
    end
  end

endmodule

//--- hdl/pq_datapath.sv
`timescale 1ns/1ps

module pq_datapath (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load,
  input  pq_ctrl_pkg::in_sel_t   in_sel,
  input  pq_data_pkg::key_t      enq_key,
  input  pq_data_pkg::key_t      rd_data,
  output pq_data_pkg::key_t      carry_key,
  output logic                   carry_less
);

  pq_data_pkg::key_t carry_d;

  ////////////////////////////////////////
  // Input select
  ////////////////////////////////////////

  // New key on enqueue start, displaced slot key on a swap
  always_comb
  begin
    case (in_sel)
      pq_ctrl_pkg::SEL_INPUT:
      begin
        carry_d = enq_key;
      end
      pq_ctrl_pkg::SEL_RAM:
      begin
        carry_d = rd_data;
      end
      default:
      begin
        carry_d = enq_key;
      end
    endcase
  end

  ////////////////////////////////////////
  // Carry register
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      carry_key <= pq_data_pkg::SENTINEL;
    end
    else if (load)
    begin
      carry_key <= carry_d;
    end
  end

  ////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////

  // Strict compare, an equal key stays behind the stored one
  assign carry_less = (carry_key < rd_data);

endmodule

//--- hdl/pq_key_ram.sv
`timescale 1ns/1ps

module pq_key_ram (
  input  logic                clk,
  input  logic                we,
  input  pq_data_pkg::addr_t  wr_addr,
  input  pq_data_pkg::key_t   wr_data,
  input  pq_data_pkg::addr_t  rd_addr,
  output pq_data_pkg::key_t   rd_data
);

  // Key storage, one entry per slot
  pq_data_pkg::key_t mem [pq_data_pkg::DEPTH];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // Registered read port
  ////////////////////////////////////////

  // Read-first: a same-cycle write shows up on the next read
  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- hdl/pq_ctrl_pkg.sv
package pq_ctrl_pkg;

  ////////////////////////////////////////
  // Control FSM states
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    IDLE            = 4'd0,
    ENQ_LOAD        = 4'd1,
    ENQ_READ        = 4'd2,
    ENQ_COMPARE     = 4'd3,
    ENQ_SWAP        = 4'd4,
    ENQ_PLACE       = 4'd5,
    DEQ_READ        = 4'd6,
    DEQ_PRESENT     = 4'd7,
    DEQ_SHIFT_READ  = 4'd8,
    DEQ_SHIFT_WRITE = 4'd9,
    DEQ_CLEAR       = 4'd10
  } pq_state_t;

  // Carry register source
  typedef enum logic {
    SEL_INPUT = 1'b0,
    SEL_RAM   = 1'b1
  } in_sel_t;

endpackage

//--- hdl/pq_data_pkg.sv
package pq_data_pkg;

  ////////////////////////////////////////
  // Queue geometry
  ////////////////////////////////////////

  // Key width in bits
  localparam int KEY_W = 16;

  // Number of key slots in the block RAM
  localparam int DEPTH = 16;

  // Slot index width, log2 of DEPTH
  localparam int ADDR_W = 4;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  typedef logic [KEY_W-1:0] key_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // One extra bit so a full queue reads as DEPTH
  typedef logic [ADDR_W:0] count_t;

  // Fill value for a free slot, sorts after every real key
  localparam key_t SENTINEL = '1;

endpackage
